/* design/coreDefs.sv */
package coreDefs;

localparam int XLEN = 32;
localparam int REG_ADDR_WIDTH = 5;
localparam int IMEM_DEPTH = 256;
localparam string IMEM_FILE = "tests/program.hex";

// RV32I major opcodes
localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_AUIPC  = 7'b0010111;
localparam logic [6:0] OP_JAL    = 7'b1101111;
localparam logic [6:0] OP_JALR   = 7'b1100111;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;
localparam logic [6:0] OP_STORE  = 7'b0100011;
localparam logic [6:0] OP_IMM    = 7'b0010011;
localparam logic [6:0] OP_REG    = 7'b0110011;

typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
} aluOp_t;

typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} srcA_t;
typedef enum logic [1:0] {B_REG, B_IMM, B_FOUR} srcB_t;

typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
} ifIdPayload_t;

typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [XLEN-1:0] imm;
    aluOp_t aluOp;
    srcA_t srcA;
    srcB_t srcB;
    logic memRead;
    logic memWrite;
    logic regWrite;
} idExPayload_t;

typedef struct packed {
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] storeData;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic memRead;
    logic memWrite;
    logic regWrite;
} exMemPayload_t;

typedef struct packed {
    logic [XLEN-1:0] result;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic regWrite;
} memWbPayload_t;

endpackage

/* design/decodeUnit.sv */
`timescale 1ns/100ps
module decodeUnit import coreDefs::*; (
    input logic clk,
    input logic rst,
    input ifIdPayload_t ifId,
    resultBusIf.sink results,
    output idExPayload_t decodeOut,
    output logic redirect,
    output logic [XLEN-1:0] redirectPc,
    output logic isBranchOrJalr,
    output logic [REG_ADDR_WIDTH-1:0] rs1,
    output logic [REG_ADDR_WIDTH-1:0] rs2
);

logic [XLEN-1:0] instr;
logic [6:0] opcode;
logic [2:0] funct3;
logic funct7b5;
logic [REG_ADDR_WIDTH-1:0] rd;
logic usesRs1, usesRs2;
logic [XLEN-1:0] immI, immS, immB, immU, immJ;
logic [XLEN-1:0] regs [1 << REG_ADDR_WIDTH];
logic memFwd;
logic [XLEN-1:0] rs1Val, rs2Val;
logic branchTaken;
logic [XLEN-1:0] targetBase, targetOffset, targetSum;
aluOp_t arithOp;

assign instr = ifId.instr;
assign opcode = instr[6:0];
assign funct3 = instr[14:12];
assign funct7b5 = instr[30];
assign rd = instr[11:7];

assign immI = {{20{instr[31]}}, instr[31:20]};
assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
assign immU = {instr[31:12], 12'b0};
assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

// Unused source fields read as x0 so they never cause a stall
assign usesRs1 = opcode inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM, OP_REG};
assign usesRs2 = opcode inside {OP_BRANCH, OP_STORE, OP_REG};
assign rs1 = usesRs1 ? instr[19:15] : '0;
assign rs2 = usesRs2 ? instr[24:20] : '0;
assign isBranchOrJalr = (opcode == OP_BRANCH) || (opcode == OP_JALR);

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < (1 << REG_ADDR_WIDTH); i++) begin
            regs[i] <= '0;
        end
    end else if (results.wbRegWrite && results.wbRd != '0) begin
        regs[results.wbRd] <= results.wbData;
    end
end

// Memory-stage ALU results first, then writeback
assign memFwd = results.memRegWrite && !results.memIsLoad;

always_comb begin
    if (rs1 == '0) rs1Val = '0;
    else if (memFwd && results.memRd == rs1) rs1Val = results.memResult;
    else if (results.wbRegWrite && results.wbRd == rs1) rs1Val = results.wbData;
    else rs1Val = regs[rs1];
end

always_comb begin
    if (rs2 == '0) rs2Val = '0;
    else if (memFwd && results.memRd == rs2) rs2Val = results.memResult;
    else if (results.wbRegWrite && results.wbRd == rs2) rs2Val = results.wbData;
    else rs2Val = regs[rs2];
end

always_comb begin
    case (funct3)
        3'b000: arithOp = (opcode == OP_REG && funct7b5) ? SUB : ADD;
        3'b001: arithOp = SLL;
        3'b010: arithOp = SLT;
        3'b011: arithOp = SLTU;
        3'b100: arithOp = XOR;
        3'b101: arithOp = funct7b5 ? SRA : SRL;
        3'b110: arithOp = OR;
        default: arithOp = AND;
    endcase
end

always_comb begin
    decodeOut = '0;
    decodeOut.pc = ifId.pc;
    decodeOut.rs1 = rs1;
    decodeOut.rs2 = rs2;
    decodeOut.rs1Data = rs1Val;
    decodeOut.rs2Data = rs2Val;
    decodeOut.rd = rd;
    case (opcode)
        OP_LUI: begin
            decodeOut.imm = immU;
            decodeOut.srcA = A_ZERO;
            decodeOut.srcB = B_IMM;
            decodeOut.aluOp = PASSB;
            decodeOut.regWrite = 1'b1;
        end
        OP_AUIPC: begin
            decodeOut.imm = immU;
            decodeOut.srcA = A_PC;
            decodeOut.srcB = B_IMM;
            decodeOut.regWrite = 1'b1;
        end
        OP_JAL, OP_JALR: begin
            // Link value pc + 4
            decodeOut.srcA = A_PC;
            decodeOut.srcB = B_FOUR;
            decodeOut.regWrite = 1'b1;
        end
        OP_LOAD: begin
            decodeOut.imm = immI;
            decodeOut.srcB = B_IMM;
            decodeOut.memRead = 1'b1;
            decodeOut.regWrite = 1'b1;
        end
        OP_STORE: begin
            decodeOut.imm = immS;
            decodeOut.srcB = B_IMM;
            decodeOut.memWrite = 1'b1;
        end
        OP_IMM: begin
            decodeOut.imm = immI;
            decodeOut.srcB = B_IMM;
            decodeOut.aluOp = arithOp;
            decodeOut.regWrite = 1'b1;
        end
        OP_REG: begin
            decodeOut.aluOp = arithOp;
            decodeOut.regWrite = 1'b1;
        end
        default: begin
            decodeOut.imm = '0;
        end
    endcase
end

always_comb begin
    case (funct3)
        3'b000: branchTaken = rs1Val == rs2Val;
        3'b001: branchTaken = rs1Val != rs2Val;
        3'b100: branchTaken = $signed(rs1Val) < $signed(rs2Val);
        3'b101: branchTaken = $signed(rs1Val) >= $signed(rs2Val);
        3'b110: branchTaken = rs1Val < rs2Val;
        3'b111: branchTaken = rs1Val >= rs2Val;
        default: branchTaken = 1'b0;
    endcase
end

assign targetBase = (opcode == OP_JALR) ? rs1Val : ifId.pc;
assign targetOffset = (opcode == OP_JALR) ? immI : ((opcode == OP_JAL) ? immJ : immB);
assign targetSum = targetBase + targetOffset;
assign redirectPc = {targetSum[XLEN-1:1], 1'b0};
assign redirect = (opcode == OP_BRANCH && branchTaken) || opcode == OP_JAL
    || opcode == OP_JALR;

endmodule

/* design/executeUnit.sv */
`timescale 1ns/100ps
module executeUnit import coreDefs::*; (
    input idExPayload_t idEx,
    resultBusIf.sink results,
    output exMemPayload_t executeOut
);

logic memFwd, wbFwd;
logic [XLEN-1:0] opA, opB;
logic [XLEN-1:0] aluA, aluB, aluResult;
logic [4:0] shamt;

// A load result is never needed here thanks to the load-use stall
assign memFwd = results.memRegWrite && !results.memIsLoad && results.memRd != '0;
assign wbFwd = results.wbRegWrite && results.wbRd != '0;

always_comb begin
    if (memFwd && results.memRd == idEx.rs1) opA = results.memResult;
    else if (wbFwd && results.wbRd == idEx.rs1) opA = results.wbData;
    else opA = idEx.rs1Data;

    if (memFwd && results.memRd == idEx.rs2) opB = results.memResult;
    else if (wbFwd && results.wbRd == idEx.rs2) opB = results.wbData;
    else opB = idEx.rs2Data;
end

always_comb begin
    case (idEx.srcA)
        A_PC: aluA = idEx.pc;
        A_ZERO: aluA = '0;
        default: aluA = opA;
    endcase
    case (idEx.srcB)
        B_IMM: aluB = idEx.imm;
        B_FOUR: aluB = XLEN'(4);
        default: aluB = opB;
    endcase
end

assign shamt = aluB[4:0];

always_comb begin
    case (idEx.aluOp)
        ADD: aluResult = aluA + aluB;
        SUB: aluResult = aluA - aluB;
        SLL: aluResult = aluA << shamt;
        SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(aluA) < $signed(aluB)};
        SLTU: aluResult = {{(XLEN-1){1'b0}}, aluA < aluB};
        XOR: aluResult = aluA ^ aluB;
        SRL: aluResult = aluA >> shamt;
        SRA: aluResult = $unsigned($signed(aluA) >>> shamt);
        OR: aluResult = aluA | aluB;
        AND: aluResult = aluA & aluB;
        PASSB: aluResult = aluB;
        default: aluResult = '0;
    endcase
end

always_comb begin
    executeOut.aluResult = aluResult;
    executeOut.storeData = opB;
    executeOut.rd = idEx.rd;
    executeOut.memRead = idEx.memRead;
    executeOut.memWrite = idEx.memWrite;
    executeOut.regWrite = idEx.regWrite;
end

endmodule

/* design/fetchUnit.sv */
`timescale 1ns/100ps
module fetchUnit import coreDefs::*; (
    input logic clk,
    input logic rst,
    input logic pcHold,
    input logic redirect,
    input logic [XLEN-1:0] redirectPc,
    output ifIdPayload_t fetchOut
);

logic [XLEN-1:0] pc;
logic [XLEN-1:0] rom [IMEM_DEPTH];

initial begin
    $readmemh(IMEM_FILE, rom);
end

// A stall wins over a redirect computed from stale operands
always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (!pcHold) begin
        if (redirect) begin
            pc <= redirectPc;
        end else begin
            pc <= pc + XLEN'(4);
        end
    end
end

// Word-addressed asynchronous read
always_comb begin
    fetchOut.pc = pc;
    fetchOut.instr = rom[pc[$clog2(IMEM_DEPTH)+1:2]];
end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/100ps
module hazardUnit import coreDefs::*; (
    input logic [REG_ADDR_WIDTH-1:0] idRs1,
    input logic [REG_ADDR_WIDTH-1:0] idRs2,
    input logic idIsBranchOrJalr,
    input idExPayload_t idEx,
    resultBusIf.sink results,
    input logic memBusy,
    input logic redirect,
    output logic fetchHold,
    output logic ifIdHold,
    output logic ifIdFlush,
    output logic idExHold,
    output logic idExFlush,
    output logic exMemHold
);

logic exMatch, memMatch;
logic loadUse, branchWait, stall;

assign exMatch = idEx.rd != '0 && (idEx.rd == idRs1 || idEx.rd == idRs2);
assign memMatch = results.memRd != '0 && (results.memRd == idRs1 || results.memRd == idRs2);

assign loadUse = idEx.memRead && exMatch;
// Branch operands come only from memory-stage ALU results or writeback
assign branchWait = idIsBranchOrJalr
    && ((idEx.regWrite && exMatch) || (results.memIsLoad && memMatch));
assign stall = loadUse || branchWait;

assign fetchHold = memBusy || stall;
assign ifIdHold = memBusy || stall;
assign ifIdFlush = redirect && !stall && !memBusy;
assign idExHold = memBusy;
assign idExFlush = stall && !memBusy;
assign exMemHold = memBusy;

endmodule

/* design/memoryStage.sv */
`timescale 1ns/100ps
module memoryStage import coreDefs::*; (
    input logic clk,
    input logic rst,
    input exMemPayload_t exMem,
    output logic memBusy,
    resultBusIf.source results,
    output logic [XLEN-1:0] awAddr,
    output logic awValid,
    input logic awReady,
    output logic [XLEN-1:0] wData,
    output logic wValid,
    input logic wReady,
    input logic bValid,
    output logic bReady,
    output logic [XLEN-1:0] arAddr,
    output logic arValid,
    input logic arReady,
    input logic [XLEN-1:0] rData,
    input logic rValid,
    output logic rReady
);

typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} memState_t;

memState_t state;
logic memOp, addrDone, respDone;
logic [XLEN-1:0] loadData;
memWbPayload_t memWbIn, memWb;

assign memOp = exMem.memRead || exMem.memWrite;

// EX/MEM is frozen while busy, so address and data stay stable
assign awAddr = exMem.aluResult;
assign arAddr = exMem.aluResult;
assign wData = exMem.storeData;

assign addrDone = !(awValid && !awReady) && !(wValid && !wReady) && !(arValid && !arReady);
assign respDone = (bReady && bValid) || (rReady && rValid);

always_ff @(posedge clk) begin
    if (rst) begin
        state <= IDLE;
        awValid <= 1'b0;
        wValid <= 1'b0;
        arValid <= 1'b0;
        bReady <= 1'b0;
        rReady <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                if (memOp) begin
                    state <= ADDR;
                    awValid <= exMem.memWrite;
                    wValid <= exMem.memWrite;
                    arValid <= exMem.memRead;
                end
            end
            ADDR: begin
                // Address and write data channels complete independently
                if (awReady) awValid <= 1'b0;
                if (wReady) wValid <= 1'b0;
                if (arReady) arValid <= 1'b0;
                if (addrDone) begin
                    state <= RESP;
                    bReady <= exMem.memWrite;
                    rReady <= exMem.memRead;
                end
            end
            RESP: begin
                if (respDone) begin
                    state <= DONE;
                    bReady <= 1'b0;
                    rReady <= 1'b0;
                end
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (rReady && rValid) begin
        loadData <= rData;
    end
end

// Pipeline advances on the edge that leaves DONE
assign memBusy = memOp && state != DONE;

always_comb begin
    memWbIn.result = exMem.memRead ? loadData : exMem.aluResult;
    memWbIn.rd = exMem.rd;
    memWbIn.regWrite = exMem.regWrite;
end

// Held while busy so the writeback value stays visible to execute
stageRegister #(.payload_t(memWbPayload_t)) memWbReg_inst (
    .clk,
    .rst,
    .hold(memBusy),
    .flush(1'b0),
    .dIn(memWbIn),
    .dOut(memWb)
);

assign results.memRegWrite = exMem.regWrite;
assign results.memRd = exMem.rd;
assign results.memResult = exMem.aluResult;
assign results.memIsLoad = exMem.memRead;
assign results.wbRegWrite = memWb.regWrite;
assign results.wbRd = memWb.rd;
assign results.wbData = memWb.result;

endmodule

/* design/resultBusIf.sv */
`timescale 1ns/100ps
interface resultBusIf import coreDefs::*;
();

// Instruction currently in the memory stage
logic memRegWrite;
logic [REG_ADDR_WIDTH-1:0] memRd;
logic [XLEN-1:0] memResult;
logic memIsLoad;

// Instruction currently in writeback
logic wbRegWrite;
logic [REG_ADDR_WIDTH-1:0] wbRd;
logic [XLEN-1:0] wbData;

modport source (
    output memRegWrite, memRd, memResult, memIsLoad,
    output wbRegWrite, wbRd, wbData
);

modport sink (
    input memRegWrite, memRd, memResult, memIsLoad,
    input wbRegWrite, wbRd, wbData
);

endinterface

/* design/rvCore.sv */
`timescale 1ns/100ps
module rvCore import coreDefs::*; (
    input logic clk,
    input logic rst,
    output logic [XLEN-1:0] awAddr,
    output logic awValid,
    input logic awReady,
    output logic [XLEN-1:0] wData,
    output logic wValid,
    input logic wReady,
    input logic bValid,
    output logic bReady,
    output logic [XLEN-1:0] arAddr,
    output logic arValid,
    input logic arReady,
    input logic [XLEN-1:0] rData,
    input logic rValid,
    output logic rReady
);

ifIdPayload_t fetchOut, ifId;
idExPayload_t decodeOut, idEx;
exMemPayload_t executeOut, exMem;
logic redirect;
logic [XLEN-1:0] redirectPc;
logic isBranchOrJalr;
logic [REG_ADDR_WIDTH-1:0] rs1, rs2;
logic memBusy;
logic fetchHold, ifIdHold, ifIdFlush, idExHold, idExFlush, exMemHold;

resultBusIf resultBus();

fetchUnit fetchUnit_inst (
    .clk,
    .rst,
    .pcHold(fetchHold),
    .redirect,
    .redirectPc,
    .fetchOut
);

stageRegister #(.payload_t(ifIdPayload_t)) ifIdReg_inst (
    .clk,
    .rst,
    .hold(ifIdHold),
    .flush(ifIdFlush),
    .dIn(fetchOut),
    .dOut(ifId)
);

decodeUnit decodeUnit_inst (
    .clk,
    .rst,
    .ifId,
    .results(resultBus.sink),
    .decodeOut,
    .redirect,
    .redirectPc,
    .isBranchOrJalr,
    .rs1,
    .rs2
);

hazardUnit hazardUnit_inst (
    .idRs1(rs1),
    .idRs2(rs2),
    .idIsBranchOrJalr(isBranchOrJalr),
    .idEx,
    .results(resultBus.sink),
    .memBusy,
    .redirect,
    .fetchHold,
    .ifIdHold,
    .ifIdFlush,
    .idExHold,
    .idExFlush,
    .exMemHold
);

stageRegister #(.payload_t(idExPayload_t)) idExReg_inst (
    .clk,
    .rst,
    .hold(idExHold),
    .flush(idExFlush),
    .dIn(decodeOut),
    .dOut(idEx)
);

executeUnit executeUnit_inst (
    .idEx,
    .results(resultBus.sink),
    .executeOut
);

stageRegister #(.payload_t(exMemPayload_t)) exMemReg_inst (
    .clk,
    .rst,
    .hold(exMemHold),
    .flush(1'b0),
    .dIn(executeOut),
    .dOut(exMem)
);

memoryStage memoryStage_inst (
    .clk,
    .rst,
    .exMem,
    .memBusy,
    .results(resultBus.source),
    .awAddr,
    .awValid,
    .awReady,
    .wData,
    .wValid,
    .wReady,
    .bValid,
    .bReady,
    .arAddr,
    .arValid,
    .arReady,
    .rData,
    .rValid,
    .rReady
);

endmodule

/* design/stageRegister.sv */
`timescale 1ns/100ps
module stageRegister #(
    parameter type payload_t = logic
)(
    input logic clk,
    input logic rst,
    input logic hold,
    input logic flush,
    input payload_t dIn,
    output payload_t dOut
);

// All-zero contents act as a bubble
always_ff @(posedge clk) begin
    if (rst || flush) begin
        dOut <= '0;
    end else if (!hold) begin
        dOut <= dIn;
    end
end

endmodule

/* sim.f */
design/coreDefs.sv
design/resultBusIf.sv
design/stageRegister.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/hazardUnit.sv
design/executeUnit.sv
design/memoryStage.sv
design/rvCore.sv
tests/coreChecker.sv
tests/coreTb.sv

/* tests/coreChecker.sv */
`timescale 1ns/100ps
module coreChecker import coreDefs::*; (
    input logic clk,
    input logic rst,
    input logic [XLEN-1:0] awAddr,
    input logic awValid,
    input logic awReady,
    input logic [XLEN-1:0] wData,
    input logic wValid,
    input logic wReady,
    input logic bValid,
    input logic bReady,
    input logic [XLEN-1:0] arAddr,
    input logic arValid,
    input logic arReady,
    input logic [XLEN-1:0] rData,
    input logic rValid,
    input logic rReady,
    output int errorCount,
    output int timeoutCount,
    output logic done
);

localparam int TXN_TIMEOUT = 300;
localparam int END_TIMEOUT = 300;
localparam int QUIET_CYCLES = 100;

typedef struct packed {
    bit isStore;
    logic [31:0] addr;
    logic [31:0] data;
} busTxn_t;

busTxn_t expQ[$];
busTxn_t obsQ[$];
logic [31:0] storeAddr, storeData, loadAddr;
logic firstStoreSeen;

function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
        logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Sequential instruction-set interpreter producing the expected bus traffic
function automatic void runReference();
    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] regs [32];
    logic [31:0] dmem [1024];
    logic [31:0] pc, instr, a, b, wr, nextPc, addr;
    logic [31:0] immI, immS, immB, immU, immJ;
    logic writes, taken, running;
    int steps;
    busTxn_t t;
    $readmemh(IMEM_FILE, imem);
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 1024; i++) dmem[i] = 32'h5a5a0000 ^ (i * 32'h9e3779b1);
    pc = '0;
    running = 1'b1;
    steps = 0;
    while (running && steps < 5000) begin
        instr = imem[pc[9:2]];
        a = regs[instr[19:15]];
        b = regs[instr[24:20]];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immU = {instr[31:12], 12'b0};
        immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        nextPc = pc + 4;
        writes = 1'b1;
        wr = '0;
        case (instr[6:0])
            OP_LUI: wr = immU;
            OP_AUIPC: wr = pc + immU;
            OP_JAL: begin
                wr = pc + 4;
                nextPc = pc + immJ;
                if (immJ == 0) running = 1'b0;
            end
            OP_JALR: begin
                wr = pc + 4;
                nextPc = (a + immI) & ~32'd1;
            end
            OP_BRANCH: begin
                writes = 1'b0;
                case (instr[14:12])
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) nextPc = pc + immB;
            end
            OP_LOAD: begin
                addr = a + immI;
                wr = dmem[addr[11:2]];
                t = '{1'b0, addr, wr};
                expQ.push_back(t);
            end
            OP_STORE: begin
                writes = 1'b0;
                addr = a + immS;
                dmem[addr[11:2]] = b;
                t = '{1'b1, addr, b};
                expQ.push_back(t);
            end
            OP_IMM: wr = aluRef(instr[14:12], instr[14:12] == 3'd5 && instr[30], a, immI);
            OP_REG: wr = aluRef(instr[14:12], instr[30], a, b);
            default: begin
                errorCount++;
                $display("Reference model met an unsupported instruction at pc %h", pc);
                running = 1'b0;
                writes = 1'b0;
            end
        endcase
        if (writes && instr[11:7] != 0) regs[instr[11:7]] = wr;
        pc = nextPc;
        steps++;
    end
    if (running) begin
        errorCount++;
        $display("Reference model never reached the closing self-jump");
    end
endfunction

// Bus monitor
always @(posedge clk) begin
    if (!rst) begin
        if (awValid && awReady) storeAddr <= awAddr;
        if (wValid && wReady) storeData <= wData;
        if (bValid && bReady) obsQ.push_back(busTxn_t'{1'b1, storeAddr, storeData});
        if (arValid && arReady) loadAddr <= arAddr;
        if (rValid && rReady) obsQ.push_back(busTxn_t'{1'b0, loadAddr, rData});
    end
end

// Outputs stay idle until the first store request
always @(posedge clk) begin
    if (rst) begin
        firstStoreSeen <= 1'b0;
    end else if (!firstStoreSeen) begin
        if (awValid) begin
            firstStoreSeen <= 1'b1;
        end else if (wValid || arValid || bReady || rReady) begin
            errorCount++;
            $display("[ERROR] %0t wValid arValid bReady rReady expected 0000 actual %b%b%b%b",
                $time, wValid, arValid, bReady, rReady);
        end
    end
end

initial begin
    busTxn_t exp;
    busTxn_t got;
    int waitCycles;
    errorCount = 0;
    timeoutCount = 0;
    done = 1'b0;
    runReference();
    waitCycles = 0;
    while (rst !== 1'b0 && waitCycles < END_TIMEOUT) begin
        @(negedge clk);
        waitCycles++;
    end
    for (int n = 0; n < expQ.size(); n++) begin
        exp = expQ[n];
        waitCycles = 0;
        while (obsQ.size() == 0 && waitCycles < TXN_TIMEOUT) begin
            @(negedge clk);
            waitCycles++;
        end
        if (obsQ.size() == 0) begin
            timeoutCount++;
            if (exp.isStore)
                $display("Store %0d to address %h never completed on the bus", n, exp.addr);
            else
                $display("Load %0d from address %h never completed on the bus", n, exp.addr);
            break;
        end
        got = obsQ.pop_front();
        if (got.isStore != exp.isStore) begin
            errorCount++;
            $display("[ERROR] %0t txn %0d kind expected %s actual %s", $time, n,
                exp.isStore ? "store" : "load", got.isStore ? "store" : "load");
        end else begin
            if (got.addr !== exp.addr) begin
                errorCount++;
                $display("[ERROR] %0t txn %0d addr expected %h actual %h", $time, n,
                    exp.addr, got.addr);
            end
            if (got.data !== exp.data) begin
                errorCount++;
                $display("[ERROR] %0t txn %0d data expected %h actual %h", $time, n,
                    exp.data, got.data);
            end
        end
    end
    // Bus must settle and stay quiet at the closing self-jump
    waitCycles = 0;
    while ((awValid || wValid || arValid || bReady || rReady) && waitCycles < END_TIMEOUT) begin
        @(negedge clk);
        waitCycles++;
    end
    if (waitCycles >= END_TIMEOUT) begin
        timeoutCount++;
        $display("Bus never went idle after the last expected transaction");
    end
    repeat (QUIET_CYCLES) @(negedge clk);
    if (obsQ.size() > 0) begin
        errorCount++;
        $display("[ERROR] %0t extra transactions expected 0 actual %0d", $time, obsQ.size());
    end
    done = 1'b1;
end

endmodule

/* tests/coreTb.sv */
`timescale 1ns/100ps
module coreTb import coreDefs::*; ();

localparam int MEM_WORDS = 1024;
localparam int RUN_TIMEOUT = 20000;

logic clk;
logic rst;
logic [XLEN-1:0] awAddr, wData, arAddr, rData;
logic awValid, awReady, wValid, wReady, bValid, bReady;
logic arValid, arReady, rValid, rReady;
logic [XLEN-1:0] mem [MEM_WORDS];
logic [XLEN-1:0] wrAddr, wrData, rdAddr;
logic awSeen, wSeen, arSeen;
logic [1:0] awCnt, wCnt, bCnt, arCnt, rCnt;
logic [31:0] lfsr;
int errorCount, timeoutCount;
logic checkDone;
int cycles;

// Galois LFSR, one step per bit taken
function automatic logic [1:0] randomDelay();
    logic [1:0] value;
    value = '0;
    for (int i = 0; i < 2; i++) begin
        value = {value[0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return value;
endfunction

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

initial begin
    lfsr = 32'h40b4faba;
    rst = 1'b1;
    awReady = 1'b0;
    wReady = 1'b0;
    bValid = 1'b0;
    arReady = 1'b0;
    rValid = 1'b0;
    rData = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = 32'h5a5a0000 ^ (i * 32'h9e3779b1);
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
end

// AXI4-Lite slave with random ready and valid delays
always @(posedge clk) begin
    if (rst) begin
        awReady <= 1'b0;
        wReady <= 1'b0;
        bValid <= 1'b0;
        arReady <= 1'b0;
        rValid <= 1'b0;
        awSeen <= 1'b0;
        wSeen <= 1'b0;
        arSeen <= 1'b0;
        awCnt <= randomDelay();
        wCnt <= randomDelay();
        bCnt <= randomDelay();
        arCnt <= randomDelay();
        rCnt <= randomDelay();
    end else begin
        if (awValid && awReady) begin
            wrAddr <= awAddr;
            awReady <= 1'b0;
            awSeen <= 1'b1;
            awCnt <= randomDelay();
        end else if (awValid && !awSeen) begin
            if (awCnt == 0) awReady <= 1'b1;
            else awCnt <= awCnt - 1;
        end
        if (wValid && wReady) begin
            wrData <= wData;
            wReady <= 1'b0;
            wSeen <= 1'b1;
            wCnt <= randomDelay();
        end else if (wValid && !wSeen) begin
            if (wCnt == 0) wReady <= 1'b1;
            else wCnt <= wCnt - 1;
        end
        // Write lands when both channels are done
        if (bValid && bReady) begin
            bValid <= 1'b0;
            awSeen <= 1'b0;
            wSeen <= 1'b0;
            bCnt <= randomDelay();
        end else if (awSeen && wSeen && !bValid) begin
            if (bCnt == 0) begin
                bValid <= 1'b1;
                mem[wrAddr[11:2]] <= wrData;
            end else begin
                bCnt <= bCnt - 1;
            end
        end
        if (arValid && arReady) begin
            rdAddr <= arAddr;
            arReady <= 1'b0;
            arSeen <= 1'b1;
            arCnt <= randomDelay();
        end else if (arValid && !arSeen) begin
            if (arCnt == 0) arReady <= 1'b1;
            else arCnt <= arCnt - 1;
        end
        if (rValid && rReady) begin
            rValid <= 1'b0;
            arSeen <= 1'b0;
            rCnt <= randomDelay();
        end else if (arSeen && !rValid) begin
            if (rCnt == 0) begin
                rValid <= 1'b1;
                rData <= mem[rdAddr[11:2]];
            end else begin
                rCnt <= rCnt - 1;
            end
        end
    end
end

rvCore rvCore_inst (
    .clk,
    .rst,
    .awAddr,
    .awValid,
    .awReady,
    .wData,
    .wValid,
    .wReady,
    .bValid,
    .bReady,
    .arAddr,
    .arValid,
    .arReady,
    .rData,
    .rValid,
    .rReady
);

coreChecker checker_inst (
    .clk,
    .rst,
    .awAddr,
    .awValid,
    .awReady,
    .wData,
    .wValid,
    .wReady,
    .bValid,
    .bReady,
    .arAddr,
    .arValid,
    .arReady,
    .rData,
    .rValid,
    .rReady,
    .errorCount,
    .timeoutCount,
    .done(checkDone)
);

initial begin
    cycles = 0;
    while (checkDone !== 1'b1 && cycles < RUN_TIMEOUT) begin
        @(posedge clk);
        cycles++;
    end
    if (checkDone !== 1'b1) begin
        $display("Checker did not finish within %0d cycles", RUN_TIMEOUT);
    end
    $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
    if (checkDone === 1'b1 && errorCount == 0 && timeoutCount == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

/* tests/program.hex */
// One 32-bit instruction word per column, four words per line, starting at address 0
// ALU results, load-use, all six branches, jal, jalr, auipc, closing self-jump
123450B7 67808093 10000513 00152023
FFB00113 001121B3 00113233 402082B3
40315333 0062C3B3 00352223 00452423
00752623 00C52403 00140493 00952823
00018463 00100613 00019463 06460613
00114463 06460613 00115463 00260613
00116463 00460613 00117463 06460613
00C52A23 00C006EF 06460613 06460613
00D52C23 09400713 000707E7 06460613
06460613 00F52E23 00052803 00180463
06460613 00001897 00309933 003159B3
01396A33 011A7AB3 011A8B33 03652023
03152223 0000006F
